// File: src/armCtrlPkg.sv
package armCtrlPkg;

  // ============================================================
  // Instruction field positions
  // ============================================================
  localparam int InstrWidth  = 32;
  localparam int CondMsb     = 31;
  localparam int CondLsb     = 28;
  localparam int ClassMsb    = 27;
  localparam int ClassLsb    = 26;
  localparam int IBit        = 25;  // Immediate / register offset select
  localparam int OpMsb       = 24;
  localparam int OpLsb       = 21;
  localparam int UBit        = 23;  // Up/down for load and store offset
  localparam int BBit        = 22;  // Byte access
  localparam int SBit        = 20;  // Set flags, data processing
  localparam int LBit        = 20;  // Load when set, load/store
  localparam int RdMsb       = 15;
  localparam int RdLsb       = 12;
  localparam int RegShiftBit = 4;   // Shift by register, undefined for LDR/STR
  localparam logic [3:0] RegPc = 4'd15;

  // ============================================================
  // Encodings
  // ============================================================
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl
  } condT;

  typedef enum logic [3:0] {
    opAnd, opEor, opSub, opRsb, opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn, opOrr, opMov, opBic, opMvn
  } aluOpT;

  typedef enum logic [1:0] {
    classDataProc = 2'b00, classLoadStore = 2'b01,
    classBranch   = 2'b10, classOther     = 2'b11
  } opClassT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Opcode sets, bit i set for opcode i
  localparam logic [15:0] LogicalOps = 16'b1111_0011_0000_0011;  // NZ update only
  localparam logic [15:0] CompareOps = 16'b0000_1111_0000_0000;  // No Rd write

endpackage

// File: src/ctrlStagePkg.sv
package ctrlStagePkg;

  // Controls held in Execute
  typedef struct packed {
    armCtrlPkg::condT  cond;
    logic              aluSrc;      // 1 selects the immediate
    armCtrlPkg::aluOpT aluControl;
    logic [1:0]        flagWrite;   // [1] NZ, [0] CV
    logic              branch;
    logic              memWrite;
    logic              memtoReg;
    logic              regWrite;
    logic              pcSrc;
    logic              byteAccess;  // LDRB/STRB
  } execCtrlT;

  // Controls held in Memory, already condition gated
  typedef struct packed {
    logic              memWrite;
    logic              memtoReg;
    logic              regWrite;
    logic              pcSrc;
    logic              setFlags;    // Flags ride along for forwarding
    armCtrlPkg::flagsT flagsNext;
    logic [3:0]        byteMask;
  } memCtrlT;

  // Controls held in Writeback
  typedef struct packed {
    logic              memtoReg;
    logic              regWrite;
    logic              pcSrc;
    logic              setFlags;
    armCtrlPkg::flagsT flagsNext;
  } wbCtrlT;

endpackage

// File: src/flagFwdIf.sv
`timescale 1ns/1ps

// Flag forwarding between the later stages, the flag register and Execute
interface flagFwdIf;
  import armCtrlPkg::*;

  flagsT flagsNextM;   // Next flags of the instruction in Memory
  logic  setFlagsM;
  flagsT flagsNextW;   // Next flags of the instruction in Writeback
  logic  setFlagsW;
  flagsT flagsE;       // Flags seen by the condition check

  // Flag register side, selects the forwarded value
  modport flags (input flagsNextM, setFlagsM, flagsNextW, setFlagsW, output flagsE);

  // Execute side
  modport exec (input flagsE);

endinterface

// File: src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  logic [armCtrlPkg::InstrWidth-1:0] instrD,
  output ctrlStagePkg::execCtrlT            dec,
  output logic [1:0]                        regSrcD,
  output logic [1:0]                        immSrcD
);
  import armCtrlPkg::*;

  logic [9:0] controls;
  logic       aluSrc, memtoReg, regWriteRaw, memWrite, branch, aluOp;
  logic [3:0] opcode;
  aluOpT      aluControl;
  logic [1:0] flagWrite;
  logic       regWrite, isCompare;
  opClassT    opClass;

  assign opClass = opClassT'(instrD[ClassMsb:ClassLsb]);
  assign opcode  = instrD[OpMsb:OpLsb];

  // Main control pattern by class and I/L bits
  // {regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch, aluOp}
  always_comb begin
    case (opClass)
      classDataProc:
        if (instrD[IBit]) controls = 10'b00_00_1_0_1_0_0_1;  // DP immediate
        else              controls = 10'b00_00_0_0_1_0_0_1;  // DP register
      classLoadStore:
        if (instrD[IBit] & instrD[RegShiftBit]) controls = '0;  // Undefined space
        else if (instrD[LBit] & ~instrD[IBit])  controls = 10'b00_01_1_1_1_0_0_0;  // LDR imm
        else if (instrD[LBit])                  controls = 10'b00_01_0_1_1_0_0_0;  // LDR reg
        else if (~instrD[IBit])                 controls = 10'b10_01_1_0_0_1_0_0;  // STR imm
        else                                    controls = 10'b10_01_0_0_0_1_0_0;  // STR reg
      classBranch:                              controls = 10'b01_10_1_0_0_0_1_0;  // B
      default:                                  controls = '0;  // Coproc, SWI
    endcase
  end

  assign {regSrcD, immSrcD, aluSrc, memtoReg, regWriteRaw, memWrite, branch, aluOp} = controls;

  // ALU opcode and flag write
  always_comb begin
    if (memtoReg | memWrite) begin
      aluControl = instrD[UBit] ? opAdd : opSub;  // Offset up or down
      flagWrite  = 2'b00;
    end else if (aluOp) begin
      aluControl = aluOpT'(opcode);
      if (!instrD[SBit])           flagWrite = 2'b00;
      else if (LogicalOps[opcode]) flagWrite = 2'b10;  // C and V kept
      else                         flagWrite = 2'b11;
    end else if (branch) begin
      aluControl = opAdd;  // PC + offset
      flagWrite  = 2'b00;
    end else begin
      aluControl = opAnd;
      flagWrite  = 2'b00;
    end
  end

  assign isCompare = aluOp & CompareOps[opcode];  // TST/TEQ/CMP/CMN
  assign regWrite  = regWriteRaw & ~isCompare;

  always_comb begin
    dec            = '0;
    dec.cond       = condT'(instrD[CondMsb:CondLsb]);
    dec.aluSrc     = aluSrc;
    dec.aluControl = aluControl;
    dec.flagWrite  = flagWrite;
    dec.branch     = branch;
    dec.memWrite   = memWrite;
    dec.memtoReg   = memtoReg;
    dec.regWrite   = regWrite;
    dec.pcSrc      = (regWrite & (instrD[RdMsb:RdLsb] == RegPc)) | branch;  // PC write
    dec.byteAccess = (memtoReg | memWrite) & instrD[BBit];
  end

endmodule

// File: src/condCheck.sv
`timescale 1ns/1ps

module condCheck (
  input  ctrlStagePkg::execCtrlT ctrlE,
  input  logic [3:0]             aluFlagsE,  // NZCV from the ALU
  flagFwdIf.exec                 fwd,
  output ctrlStagePkg::memCtrlT  gated,
  output logic                   setFlagsE,
  output armCtrlPkg::flagsT      flagsNextE,
  output logic                   branchTakenE
);
  import armCtrlPkg::*;

  flagsT cur, alu;
  logic  condEx;

  assign cur = fwd.flagsE;  // Already forwarded
  assign alu = flagsT'(aluFlagsE);

  // ARM condition table
  always_comb begin
    case (ctrlE.cond)
      condEq:  condEx = cur.z;
      condNe:  condEx = ~cur.z;
      condCs:  condEx = cur.c;
      condCc:  condEx = ~cur.c;
      condMi:  condEx = cur.n;
      condPl:  condEx = ~cur.n;
      condVs:  condEx = cur.v;
      condVc:  condEx = ~cur.v;
      condHi:  condEx = cur.c & ~cur.z;
      condLs:  condEx = ~cur.c | cur.z;
      condGe:  condEx = (cur.n == cur.v);
      condLt:  condEx = (cur.n != cur.v);
      condGt:  condEx = ~cur.z & (cur.n == cur.v);
      condLe:  condEx = cur.z | (cur.n != cur.v);
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;  // NV space, never executes
    endcase
  end

  // Next flags, logical ops keep C and V
  always_comb begin
    flagsNextE.n = ctrlE.flagWrite[1] ? alu.n : cur.n;
    flagsNextE.z = ctrlE.flagWrite[1] ? alu.z : cur.z;
    flagsNextE.c = ctrlE.flagWrite[0] ? alu.c : cur.c;
    flagsNextE.v = ctrlE.flagWrite[0] ? alu.v : cur.v;
  end

  assign setFlagsE    = (ctrlE.flagWrite != 2'b00) & condEx;
  assign branchTakenE = ctrlE.branch & condEx;

  // Write gating, mask and flags filled in by the top
  always_comb begin
    gated          = '0;
    gated.memWrite = ctrlE.memWrite & condEx;
    gated.memtoReg = ctrlE.memtoReg & condEx;  // No read on a failed condition
    gated.regWrite = ctrlE.regWrite & condEx;
    gated.pcSrc    = ctrlE.pcSrc & condEx;
  end

endmodule

// File: src/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    stall,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // Stall beats flush, reset beats both
  always_ff @(posedge clk) begin
    if (reset)       q <= '0;
    else if (!stall) begin
      if (flush) q <= '0;  // Bubble
      else       q <= d;
    end
  end

endmodule

// File: src/flagRegister.sv
`timescale 1ns/1ps

module flagRegister (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  flagFwdIf.flags           fwd,
  output armCtrlPkg::flagsT flagsNzcv
);

  // ============================================================
  // NZCV state, written from Writeback
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      flagsNzcv <= '0;
    end else if (!stall && fwd.setFlagsW) begin
      flagsNzcv <= fwd.flagsNextW;
    end
  end

  // ============================================================
  // Forwarding to Execute
  // ============================================================
  // Youngest producer wins
  always_comb begin
    if (fwd.setFlagsM)      fwd.flagsE = fwd.flagsNextM;
    else if (fwd.setFlagsW) fwd.flagsE = fwd.flagsNextW;
    else                    fwd.flagsE = flagsNzcv;
  end

endmodule

// File: src/armController.sv
`timescale 1ns/1ps

module armController (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [armCtrlPkg::InstrWidth-1:0] instrD,
  input  logic [3:0]                        aluFlagsE,
  input  logic [1:0]                        addrLowE,
  input  logic                              stall,
  input  logic                              flushE,
  output logic [1:0]                        regSrcD,
  output logic [1:0]                        immSrcD,
  output logic                              aluSrcE,
  output logic [3:0]                        aluControlE,
  output logic                              branchTakenE,
  output logic                              memWriteM,
  output logic [3:0]                        byteMaskM,
  output logic                              memtoRegW,
  output logic                              regWriteW,
  output logic                              pcSrcW,
  output logic [3:0]                        flagsNzcv
);
  import armCtrlPkg::*;
  import ctrlStagePkg::*;

  execCtrlT decD, ctrlE;
  memCtrlT  gatedE, memE, ctrlM;
  wbCtrlT   wbM, ctrlW;
  logic     setFlagsE;
  flagsT    flagsNextE, flagsQ;
  logic [3:0] byteMaskE;

  flagFwdIf u_flagFwd ();

  // ============================================================
  // Decode
  // ============================================================
  instrDecoder u_instrDecoder (.instrD, .dec(decD), .regSrcD, .immSrcD);

  stageReg #(.payloadT(execCtrlT)) u_regE (
    .clk, .reset, .stall, .flush(flushE), .d(decD), .q(ctrlE));

  // ============================================================
  // Execute
  // ============================================================
  condCheck u_condCheck (
    .ctrlE, .aluFlagsE, .fwd(u_flagFwd.exec), .gated(gatedE),
    .setFlagsE, .flagsNextE, .branchTakenE);

  // Word store writes all lanes, byte store one lane
  assign byteMaskE = ctrlE.byteAccess ? (4'b0001 << addrLowE) : 4'b1111;

  always_comb begin
    memE           = gatedE;
    memE.byteMask  = byteMaskE;
    memE.setFlags  = setFlagsE;
    memE.flagsNext = flagsNextE;
  end

  assign aluSrcE     = ctrlE.aluSrc;
  assign aluControlE = ctrlE.aluControl;

  stageReg #(.payloadT(memCtrlT)) u_regM (
    .clk, .reset, .stall, .flush(1'b0), .d(memE), .q(ctrlM));

  // ============================================================
  // Memory and Writeback
  // ============================================================
  assign wbM = '{memtoReg: ctrlM.memtoReg, regWrite: ctrlM.regWrite, pcSrc: ctrlM.pcSrc,
                 setFlags: ctrlM.setFlags, flagsNext: ctrlM.flagsNext};

  stageReg #(.payloadT(wbCtrlT)) u_regW (
    .clk, .reset, .stall, .flush(1'b0), .d(wbM), .q(ctrlW));

  assign u_flagFwd.flagsNextM = ctrlM.flagsNext;  // Forward sources
  assign u_flagFwd.setFlagsM  = ctrlM.setFlags;
  assign u_flagFwd.flagsNextW = ctrlW.flagsNext;
  assign u_flagFwd.setFlagsW  = ctrlW.setFlags;

  flagRegister u_flagRegister (
    .clk, .reset, .stall, .fwd(u_flagFwd.flags), .flagsNzcv(flagsQ));

  assign memWriteM = ctrlM.memWrite;
  assign byteMaskM = ctrlM.byteMask;
  assign memtoRegW = ctrlW.memtoReg;
  assign regWriteW = ctrlW.regWrite;
  assign pcSrcW    = ctrlW.pcSrc;
  assign flagsNzcv = flagsQ;

endmodule

// File: bench/armController_chk.sv
`timescale 1ns/1ps

module armController_chk (
  input logic       clk,
  input logic       reset,
  input logic       stall,
  input logic       regWriteW,
  input logic       memWriteM,
  input logic [3:0] byteMaskM,
  input logic [3:0] flagsNzcv
);

  // No writes come out of a reset edge
  resetQuiet: assert property (@(posedge clk) reset |=> (!regWriteW && !memWriteM))
    else $error("regWriteW or memWriteM high after reset");

  stallHoldsFlags: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(flagsNzcv))
    else $error("flagsNzcv changed during stall");

  // Zero only before the first instruction reaches Memory
  maskShape: assert property (@(posedge clk) disable iff (reset)
    ($onehot0(byteMaskM) || byteMaskM == 4'b1111))
    else $error("byteMaskM neither one-hot nor all ones");

endmodule

bind armController armController_chk u_armControllerChk (.*);

// File: bench/ctrlScoreboard.sv
`timescale 1ns/1ps

module ctrlScoreboard (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] instrD,
  input  logic [3:0]  aluFlagsE,
  input  logic [1:0]  addrLowE,
  input  logic        stall,
  input  logic        flushE,
  input  logic [1:0]  regSrcD,
  input  logic [1:0]  immSrcD,
  input  logic        aluSrcE,
  input  logic [3:0]  aluControlE,
  input  logic        branchTakenE,
  input  logic        memWriteM,
  input  logic [3:0]  byteMaskM,
  input  logic        memtoRegW,
  input  logic        regWriteW,
  input  logic        pcSrcW,
  input  logic [3:0]  flagsNzcv,
  output int          errorCount,
  output int          checkCount
);

  typedef struct packed {
    logic [1:0] regSrc, immSrc;
    logic [3:0] cond;
    logic       aluSrc;
    logic [3:0] aluCtrl;
    logic       nzW, cvW, branch, memWrite, memtoReg, regWrite, pcSrc, byteAcc;
  } refCtrlT;

  // Model pipeline state
  refCtrlT    eS;
  logic       mWrite, mSet, wMemtoReg, wRegWrite, wPcSrc, wSet;
  logic [3:0] mMask, mNext, wNext, arch;
  logic       mMemtoReg, mRegWrite, mPcSrc;

  initial begin
    errorCount = 0;
    checkCount = 0;
  end

  // Expected controls from the ARM class table
  function automatic refCtrlT refDecode(input logic [31:0] ins);
    refCtrlT r;
    logic [3:0] op;
    logic logical, compare;
    r = '0;
    op = ins[24:21];
    logical = op inside {4'd0, 4'd1, 4'd8, 4'd9, 4'd12, 4'd13, 4'd14, 4'd15};
    compare = op inside {[4'd8:4'd11]};
    r.cond = ins[31:28];
    case (ins[27:26])
      2'b00: begin
        r.aluSrc = ins[25];
        r.aluCtrl = op;
        r.regWrite = !compare;
        r.nzW = ins[20];
        r.cvW = ins[20] & !logical;
      end
      2'b01: if (!(ins[25] && ins[4])) begin  // I with bit 4 is undefined
        r.immSrc = 2'b01;
        r.aluSrc = !ins[25];
        r.aluCtrl = ins[23] ? 4'd4 : 4'd2;  // ADD or SUB offset
        r.byteAcc = ins[22];
        if (ins[20]) begin
          r.memtoReg = 1'b1;
          r.regWrite = 1'b1;
        end else begin
          r.memWrite = 1'b1;
          r.regSrc = 2'b10;
        end
      end
      2'b10: begin
        r.regSrc = 2'b01;
        r.immSrc = 2'b10;
        r.aluSrc = 1'b1;
        r.aluCtrl = 4'd4;
        r.branch = 1'b1;
      end
      default: ;
    endcase
    r.pcSrc = r.branch | (r.regWrite && ins[15:12] == 4'hf);
    return r;
  endfunction

  function automatic logic condPass(input logic [3:0] c, input logic [3:0] f);
    logic n, z, cy, v;
    {n, z, cy, v} = f;
    case (c)
      4'd0:  return z;
      4'd1:  return !z;
      4'd2:  return cy;
      4'd3:  return !cy;
      4'd4:  return n;
      4'd5:  return !n;
      4'd6:  return v;
      4'd7:  return !v;
      4'd8:  return cy && !z;
      4'd9:  return !cy || z;
      4'd10: return n == v;
      4'd11: return n != v;
      4'd12: return !z && n == v;
      4'd13: return z || n != v;
      4'd14: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // ============================================================
  // Compare before the edge, then advance the model
  // ============================================================
  always @(posedge clk) begin : compareStep
    refCtrlT dRef;
    logic [3:0] fwd, nxt;
    logic pass;
    dRef = refDecode(instrD);
    fwd = mSet ? mNext : (wSet ? wNext : arch);  // M beats W beats register
    pass = condPass(eS.cond, fwd);
    nxt = fwd;
    if (eS.nzW) nxt[3:2] = aluFlagsE[3:2];
    if (eS.cvW) nxt[1:0] = aluFlagsE[1:0];
    if (reset) begin
      eS = '0;
      {mWrite, mSet, mMemtoReg, mRegWrite, mPcSrc} = '0;
      {wMemtoReg, wRegWrite, wPcSrc, wSet} = '0;
      {mMask, mNext, wNext, arch} = '0;
    end else begin
      checkField("regSrcD", 32'(regSrcD), 32'(dRef.regSrc));
      checkField("immSrcD", 32'(immSrcD), 32'(dRef.immSrc));
      checkField("aluSrcE", 32'(aluSrcE), 32'(eS.aluSrc));
      checkField("aluControlE", 32'(aluControlE), 32'(eS.aluCtrl));
      checkField("branchTakenE", 32'(branchTakenE), 32'(eS.branch & pass));
      checkField("memWriteM", 32'(memWriteM), 32'(mWrite));
      checkField("byteMaskM", 32'(byteMaskM), 32'(mMask));
      checkField("memtoRegW", 32'(memtoRegW), 32'(wMemtoReg));
      checkField("regWriteW", 32'(regWriteW), 32'(wRegWrite));
      checkField("pcSrcW", 32'(pcSrcW), 32'(wPcSrc));
      checkField("flagsNzcv", 32'(flagsNzcv), 32'(arch));
      if (!stall) begin  // Oldest stage first
        if (wSet) arch = wNext;
        {wMemtoReg, wRegWrite, wPcSrc, wSet, wNext} =
          {mMemtoReg, mRegWrite, mPcSrc, mSet, mNext};
        mWrite = eS.memWrite & pass;
        mMemtoReg = eS.memtoReg & pass;
        mRegWrite = eS.regWrite & pass;
        mPcSrc = eS.pcSrc & pass;
        mSet = (eS.nzW | eS.cvW) & pass;
        mNext = nxt;
        mMask = 4'b1111;  // Word access, all lanes
        if (eS.byteAcc) begin
          mMask = 4'b0000;
          mMask[addrLowE] = 1'b1;  // Lane picked by the low address
        end
        eS = flushE ? refCtrlT'('0) : dRef;  // Bubble on flush
      end
    end
  end

endmodule

// File: bench/armControllerTb.sv
`timescale 1ns/1ps

module armControllerTb;

  localparam int ClkPeriod = 8;
  localparam int Seed      = 32'hcdc6;
  localparam int TestCount = 6;
  localparam int MaxCycles = 5000;  // Watchdog bound
  localparam logic [31:0] Nop = 32'hEC00_0000;  // Class 11, decodes to zero controls

  logic        clk, reset, stall, flushE;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE, aluControlE, byteMaskM, flagsNzcv;
  logic [1:0]  addrLowE, regSrcD, immSrcD;
  logic        aluSrcE, branchTakenE, memWriteM, memtoRegW, regWriteW, pcSrcW;
  int          errorCount, checkCount;
  int          errBefore, chkBefore, testsRun;

  armController u_armController (.*);
  ctrlScoreboard u_scoreboard (.*);

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ============================================================
  // Stimulus helpers
  // ============================================================
  // One cycle of inputs, applied on the falling edge
  task automatic step(input logic [31:0] ins, input logic [3:0] alu, input logic [1:0] addr,
                      input logic st, input logic fl);
    @(negedge clk);
    instrD    = ins;
    aluFlagsE = alu;
    addrLowE  = addr;
    stall     = st;
    flushE    = fl;
  endtask

  function automatic logic [31:0] dpInstr(input logic [3:0] cond, input logic [3:0] op,
                                          input logic s, input logic i, input logic [3:0] rd);
    logic [31:0] r;
    r = $urandom;
    r[31:28] = cond;
    r[27:26] = 2'b00;
    r[25] = i;
    r[24:21] = op;
    r[20] = s;
    r[15:12] = rd;
    return r;
  endfunction

  function automatic logic [31:0] lsInstr(input logic [3:0] cond, input logic i,
                                          input logic b, input logic l);
    logic [31:0] r;
    r = $urandom;  // U, Rd and offset random
    r[31:28] = cond;
    r[27:26] = 2'b01;
    r[25] = i;
    r[22] = b;
    r[20] = l;
    return r;
  endfunction

  function automatic logic [31:0] brInstr(input logic [3:0] cond);
    return {cond, 3'b101, 25'($urandom)};
  endfunction

  function automatic logic [31:0] anyInstr();
    logic [3:0] c;
    c = 4'($urandom % 15);
    case ($urandom % 3)
      0:       return dpInstr(c, 4'($urandom), 1'($urandom), 1'($urandom), 4'($urandom));
      1:       return lsInstr(c, 1'($urandom), 1'($urandom), 1'($urandom));
      default: return brInstr(c);
    endcase
  endfunction

  // Flush the pipe with bubbles, then report the test
  task automatic finishTest(input string name);
    for (int k = 0; k < 6; k++) step(Nop, 4'h0, 2'd0, 1'b0, 1'b0);
    testsRun++;
    $display("%s: %0d checks, %0d errors", name, checkCount - chkBefore,
             errorCount - errBefore);
    errBefore = errorCount;
    chkBefore = checkCount;
  endtask

  // ============================================================
  // Tests
  // ============================================================
  initial begin
    void'($urandom(Seed));
    reset = 1'b1;
    stall = 1'b0;
    flushE = 1'b0;
    instrD = Nop;
    aluFlagsE = 4'h0;
    addrLowE = 2'd0;
    testsRun = 0;
    errBefore = 0;
    chkBefore = 0;
    for (int k = 0; k < 4; k++) @(negedge clk);  // Reset for 4 cycles
    reset = 1'b0;

    for (int k = 0; k < 40; k++) begin  // All four classes in turn
      logic [31:0] ins;
      ins = $urandom;
      ins[27:26] = 2'(k);
      step(ins, 4'($urandom), 2'($urandom), 1'b0, 1'b0);
    end
    finishTest("decode patterns");

    for (int k = 0; k < 80; k++) step(anyInstr(), 4'($urandom), 2'($urandom), 1'b0, 1'b0);
    finishTest("conditional execution");

    for (int k = 0; k < 40; k++) begin  // Back to back S-bit ops
      logic [3:0] c;
      c = (k % 3 == 0) ? 4'he : 4'($urandom % 15);
      step(dpInstr(c, 4'($urandom), 1'b1, 1'($urandom), 4'($urandom)),
           4'($urandom), 2'd0, 1'b0, 1'b0);
    end
    finishTest("flag update and forwarding");

    for (int a = 0; a < 4; a++) begin
      step(lsInstr(4'he, 1'b0, 1'b1, 1'b0), 4'h0, 2'(a), 1'b0, 1'b0);  // STRB
      step(lsInstr(4'he, 1'b0, 1'b0, 1'b0), 4'h0, 2'(a), 1'b0, 1'b0);  // STR
    end
    finishTest("byte mask");

    for (int k = 0; k < 40; k++)
      step(anyInstr(), 4'($urandom), 2'($urandom), 1'b0, 1'($urandom % 4 == 0));
    for (int b = 0; b < 6; b++) begin
      int len;
      len = 1 + int'($urandom % 6);
      step(anyInstr(), 4'($urandom), 2'($urandom), 1'b0, 1'b0);
      for (int k = 0; k < len; k++)
        step(anyInstr(), 4'($urandom), 2'($urandom), 1'b1, 1'($urandom % 2));  // Stall beats flush
    end
    finishTest("flush and stall");

    for (int k = 0; k < 40; k++) begin
      logic [3:0] c;
      c = 4'($urandom % 15);
      case (k % 3)
        0:       step(brInstr(c), 4'($urandom), 2'd0, 1'b0, 1'b0);
        1:       step(dpInstr(c, 4'($urandom), 1'($urandom), 1'b1, 4'hf),
                      4'($urandom), 2'd0, 1'b0, 1'b0);
        default: step(dpInstr(c, 4'(8 + $urandom % 4), 1'b1, 1'b0, 4'($urandom)),
                      4'($urandom), 2'd0, 1'b0, 1'b0);  // TST..CMN
      endcase
    end
    finishTest("pc write and compares");

    $display("Tests run: %0d of %0d, checks: %0d, errors: %0d", testsRun, TestCount,
             checkCount, errorCount);
    if (errorCount == 0 && testsRun == TestCount) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    for (int k = 0; k < MaxCycles; k++) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
    $display("Test failed");
    $finish;
  end

endmodule

// File: flist.f
src/armCtrlPkg.sv
src/ctrlStagePkg.sv
src/flagFwdIf.sv
src/instrDecoder.sv
src/condCheck.sv
src/stageReg.sv
src/flagRegister.sv
src/armController.sv
bench/armController_chk.sv
bench/ctrlScoreboard.sv
bench/armControllerTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the armController testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module armControllerTb -f flist.f -o simv
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "$out" | grep -q "^Test completed successfully$" || exit 1
exit 0
